/* src/exec_pkg.sv */
package exec_pkg;

  // Data path and register index widths
  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  typedef logic [XLEN-1:0]     word_t;
  typedef logic [REG_BITS-1:0] reg_addr_t;
  typedef logic [3:0]          op_code_t;
  typedef logic [2:0]          branch_cond_t;

  // ALU operation encodings carried in op_code_t
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // Muldiv path decodes only the low two bits of op_code_t
  typedef enum logic [1:0] {
    MD_MUL   = 2'd0,
    MD_MULHU = 2'd1,
    MD_DIVU  = 2'd2,
    MD_REMU  = 2'd3
  } muldiv_op_e;

  typedef enum logic {
    PATH_ALU    = 1'b0,
    PATH_MULDIV = 1'b1
  } exec_path_e;

  // RV32 branch funct3 encodings
  // Codes 010 and 011 never branch
  localparam branch_cond_t BR_EQ  = 3'b000;
  localparam branch_cond_t BR_NE  = 3'b001;
  localparam branch_cond_t BR_LT  = 3'b100;
  localparam branch_cond_t BR_GE  = 3'b101;
  localparam branch_cond_t BR_LTU = 3'b110;
  localparam branch_cond_t BR_GEU = 3'b111;

endpackage

/* src/exec_ifs.sv */
////////////////////////////////////////////////////////////////////////////
// Issued operation with forwarded operands
////////////////////////////////////////////////////////////////////////////

interface operand_bundle_if import exec_pkg::*; ();

  logic         valid;
  exec_path_e   path;
  op_code_t     op;
  word_t        operand1;
  word_t        operand2;
  reg_addr_t    rd;
  logic         branch;
  branch_cond_t cond;
  word_t        pc;
  word_t        imm;

  modport producer (
    output valid, path, op, operand1, operand2, rd, branch, cond, pc, imm
  );

  modport consumer (
    input valid, path, op, operand1, operand2, rd, branch, cond, pc, imm
  );

endinterface

////////////////////////////////////////////////////////////////////////////
// Registered ALU result with compare flags
////////////////////////////////////////////////////////////////////////////

interface alu_result_if import exec_pkg::*; ();

  logic         valid;
  reg_addr_t    rd;
  word_t        data;
  logic         branch;
  branch_cond_t cond;
  logic         equal;
  logic         less;
  logic         less_signed;
  word_t        target;

  modport producer (
    output valid, rd, data, branch, cond, equal, less, less_signed, target
  );

  modport consumer (
    input valid, rd, data, branch, cond, equal, less, less_signed, target
  );

  // Operand fetch only needs the bypass value
  modport forward (
    input valid, rd, data
  );

endinterface

/* src/operand_fetch.sv */
module operand_fetch import exec_pkg::*; #(
  parameter int XLEN     = exec_pkg::XLEN,
  parameter int REG_BITS = exec_pkg::REG_BITS
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      issue_i,
  output logic                      busy_o,
  input  exec_path_e                path_i,
  input  op_code_t                  op_i,
  input  reg_addr_t                 rs1_i,
  input  reg_addr_t                 rs2_i,
  input  reg_addr_t                 rd_i,
  input  word_t                     imm_i,
  input  logic                      use_imm_i,
  input  logic                      branch_i,
  input  branch_cond_t              cond_i,
  input  word_t                     pc_i,
  input  logic                      wb_valid_i,
  input  reg_addr_t                 wb_rd_i,
  input  word_t                     wb_data_i,
  input  logic                      muldiv_busy_i,
  input  logic                      flush_i,
  operand_bundle_if.producer        bundle,
  alu_result_if.forward             fwd
);

  localparam int NUM_REGS = 2 ** REG_BITS;

  // Register 0 has no storage
  logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

  logic         accept;
  logic         fs_valid_q;
  exec_path_e   fs_path_q;
  op_code_t     fs_op_q;
  reg_addr_t    fs_rs1_q;
  reg_addr_t    fs_rs2_q;
  reg_addr_t    fs_rd_q;
  word_t        fs_imm_q;
  logic         fs_use_imm_q;
  logic         fs_branch_q;
  branch_cond_t fs_cond_q;
  word_t        fs_pc_q;

  // ALU result register is checked before writeback and writeback before the file
  function automatic word_t read_operand(reg_addr_t idx);
    word_t value;
    if (idx == '0) begin
      value = '0;
    end else if (fwd.valid && fwd.rd == idx) begin
      value = fwd.data;
    end else if (wb_valid_i && wb_rd_i == idx) begin
      value = wb_data_i;
    end else begin
      value = regs_q[idx];
    end
    return value;
  endfunction

  // A muldiv in this stage holds issue until the muldiv path takes over
  assign busy_o = muldiv_busy_i || flush_i || (fs_valid_q && fs_path_q == PATH_MULDIV);
  assign accept = issue_i && !busy_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_valid_i && wb_rd_i != '0) begin
      regs_q[wb_rd_i] <= wb_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fetch-stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      fs_valid_q <= 1'b0;
    end else begin
      fs_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      fs_path_q    <= path_i;
      fs_op_q      <= op_i;
      fs_rs1_q     <= rs1_i;
      fs_rs2_q     <= rs2_i;
      fs_rd_q      <= rd_i;
      fs_imm_q     <= imm_i;
      // Branches always compare against rs2
      fs_use_imm_q <= use_imm_i && !branch_i;
      fs_branch_q  <= branch_i;
      fs_cond_q    <= cond_i;
      fs_pc_q      <= pc_i;
    end
  end

  assign bundle.valid    = fs_valid_q;
  assign bundle.path     = fs_path_q;
  assign bundle.op       = fs_op_q;
  assign bundle.operand1 = read_operand(fs_rs1_q);
  assign bundle.operand2 = fs_use_imm_q ? fs_imm_q : read_operand(fs_rs2_q);
  assign bundle.rd       = fs_rd_q;
  assign bundle.branch   = fs_branch_q;
  assign bundle.cond     = fs_cond_q;
  assign bundle.pc       = fs_pc_q;
  assign bundle.imm      = fs_imm_q;

endmodule

/* src/alu_path.sv */
module alu_path import exec_pkg::*; #(
  parameter int XLEN     = exec_pkg::XLEN,
  parameter int REG_BITS = exec_pkg::REG_BITS
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               flush_i,
  operand_bundle_if.consumer bundle,
  alu_result_if.producer     result
);

  localparam int SHAMT_BITS = $clog2(XLEN);

  logic                  accept;
  logic [SHAMT_BITS-1:0] shamt;
  logic                  equal;
  logic                  less;
  logic                  less_signed;
  logic [XLEN-1:0]       alu_res;

  assign accept = bundle.valid && bundle.path == PATH_ALU;
  assign shamt  = bundle.operand2[SHAMT_BITS-1:0];

  // Compare flags feed both SLT/SLTU and the branch conditions
  assign equal       = bundle.operand1 == bundle.operand2;
  assign less        = bundle.operand1 < bundle.operand2;
  assign less_signed = $signed(bundle.operand1) < $signed(bundle.operand2);

  always_comb begin
    case (alu_op_e'(bundle.op))
      ALU_ADD:  alu_res = bundle.operand1 + bundle.operand2;
      ALU_SUB:  alu_res = bundle.operand1 - bundle.operand2;
      ALU_AND:  alu_res = bundle.operand1 & bundle.operand2;
      ALU_OR:   alu_res = bundle.operand1 | bundle.operand2;
      ALU_XOR:  alu_res = bundle.operand1 ^ bundle.operand2;
      ALU_SLL:  alu_res = bundle.operand1 << shamt;
      ALU_SRL:  alu_res = bundle.operand1 >> shamt;
      ALU_SRA:  alu_res = $signed(bundle.operand1) >>> shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, less_signed};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, less};
      default:  alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      // Branches carry no destination so they never forward
      result.rd          <= bundle.branch ? {REG_BITS{1'b0}} : bundle.rd;
      result.data        <= alu_res;
      result.branch      <= bundle.branch;
      result.cond        <= bundle.cond;
      result.equal       <= equal;
      result.less        <= less;
      result.less_signed <= less_signed;
      result.target      <= bundle.pc + bundle.imm;
    end
  end

endmodule

/* src/muldiv_path.sv */
module muldiv_path import exec_pkg::*; #(
  parameter int XLEN     = exec_pkg::XLEN,
  parameter int REG_BITS = exec_pkg::REG_BITS
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               flush_i,
  operand_bundle_if.consumer bundle,
  output logic               busy_o,
  output logic               done_o,
  output reg_addr_t          rd_o,
  output word_t              result_o
);

  localparam int CNT_BITS = $clog2(XLEN);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } md_state_e;

  md_state_e             state_q;
  logic [CNT_BITS-1:0]   count_q;
  muldiv_op_e            op_q;
  logic [REG_BITS-1:0]   rd_q;
  logic [XLEN-1:0]       operand_q;
  // High half is product accumulator or remainder, low half multiplier or quotient
  logic [2*XLEN-1:0]     acc_q;
  logic [2*XLEN-1:0]     acc_d;
  logic [XLEN:0]         sum;
  logic [XLEN:0]         rem_s;
  logic [XLEN:0]         diff;
  logic                  accept;
  logic                  is_div;

  assign accept = state_q == ST_IDLE && bundle.valid && bundle.path == PATH_MULDIV;
  assign is_div = op_q == MD_DIVU || op_q == MD_REMU;

  // One shift-add or restoring shift-subtract step
  always_comb begin
    sum   = {1'b0, acc_q[2*XLEN-1:XLEN]} + {1'b0, operand_q};
    rem_s = acc_q[2*XLEN-1:XLEN-1];
    diff  = rem_s - {1'b0, operand_q};
    if (is_div) begin
      if (!diff[XLEN]) begin
        acc_d = {diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
      end else begin
        acc_d = {rem_s[XLEN-1:0], acc_q[XLEN-2:0], 1'b0};
      end
    end else if (acc_q[0]) begin
      acc_d = {sum, acc_q[XLEN-1:1]};
    end else begin
      acc_d = {1'b0, acc_q[2*XLEN-1:1]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_RUN;
        ST_RUN:  if (count_q == CNT_BITS'(XLEN-1)) state_q <= ST_DONE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= muldiv_op_e'(bundle.op[1:0]);
      rd_q      <= bundle.rd;
      operand_q <= bundle.operand2;
      acc_q     <= {{XLEN{1'b0}}, bundle.operand1};
      count_q   <= '0;
    end else if (state_q == ST_RUN) begin
      acc_q   <= acc_d;
      count_q <= count_q + 1'b1;
    end
  end

  assign busy_o   = state_q != ST_IDLE;
  assign done_o   = state_q == ST_DONE;
  assign rd_o     = rd_q;
  // MULHU and REMU take the high half
  assign result_o = (op_q == MD_MULHU || op_q == MD_REMU) ? acc_q[2*XLEN-1:XLEN]
                                                           : acc_q[XLEN-1:0];

endmodule

/* src/retire_unit.sv */
module retire_unit import exec_pkg::*; #(
  parameter int XLEN     = exec_pkg::XLEN,
  parameter int REG_BITS = exec_pkg::REG_BITS
) (
  input  logic           clk_i,
  input  logic           reset_i,
  alu_result_if.consumer alu,
  input  logic           muldiv_done_i,
  input  reg_addr_t      muldiv_rd_i,
  input  word_t          muldiv_result_i,
  output logic           wb_valid_o,
  output reg_addr_t      wb_rd_o,
  output word_t          wb_data_o,
  output logic           branch_taken_o,
  output word_t          branch_target_o
);

  logic                wb_valid_q;
  logic [REG_BITS-1:0] wb_rd_q;
  logic [XLEN-1:0]     wb_data_q;
  logic                taken_q;
  logic [XLEN-1:0]     target_q;
  logic                cond_met;
  logic                alu_write;
  logic                muldiv_write;

  always_comb begin
    case (alu.cond)
      BR_EQ:   cond_met = alu.equal;
      BR_NE:   cond_met = !alu.equal;
      BR_LT:   cond_met = alu.less_signed;
      BR_GE:   cond_met = !alu.less_signed;
      BR_LTU:  cond_met = alu.less;
      BR_GEU:  cond_met = !alu.less;
      default: cond_met = 1'b0;
    endcase
  end

  // Writes to x0 are dropped here
  assign alu_write    = alu.valid && !alu.branch && alu.rd != '0;
  assign muldiv_write = muldiv_done_i && muldiv_rd_i != '0;

  // Taken flag is also the flush, so it clears itself after one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || taken_q) begin
      wb_valid_q <= 1'b0;
      taken_q    <= 1'b0;
    end else begin
      wb_valid_q <= alu_write || muldiv_write;
      taken_q    <= alu.valid && alu.branch && cond_met;
    end
  end

  always_ff @(posedge clk_i) begin
    if (muldiv_done_i) begin
      wb_rd_q   <= muldiv_rd_i;
      wb_data_q <= muldiv_result_i;
    end else if (alu.valid) begin
      wb_rd_q   <= alu.rd;
      wb_data_q <= alu.data;
    end
    if (alu.valid && alu.branch) begin
      target_q <= alu.target;
    end
  end

  assign wb_valid_o      = wb_valid_q;
  assign wb_rd_o         = wb_rd_q;
  assign wb_data_o       = wb_data_q;
  assign branch_taken_o  = taken_q;
  assign branch_target_o = target_q;

endmodule

/* src/exec_core.sv */
module exec_core import exec_pkg::*; #(
  parameter int XLEN     = exec_pkg::XLEN,
  parameter int REG_BITS = exec_pkg::REG_BITS
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         issue_i,
  output logic         busy_o,
  input  exec_path_e   path_i,
  input  op_code_t     op_i,
  input  reg_addr_t    rs1_i,
  input  reg_addr_t    rs2_i,
  input  reg_addr_t    rd_i,
  input  word_t        imm_i,
  input  logic         use_imm_i,
  input  logic         branch_i,
  input  branch_cond_t cond_i,
  input  word_t        pc_i,
  output logic         wb_valid_o,
  output reg_addr_t    wb_rd_o,
  output word_t        wb_data_o,
  output logic         branch_taken_o,
  output word_t        branch_target_o
);

  operand_bundle_if bundle_if ();
  alu_result_if     alu_res_if ();

  logic      muldiv_busy;
  logic      muldiv_done;
  reg_addr_t muldiv_rd;
  word_t     muldiv_result;

  ////////////////////////////////////////////////////////////////////////////
  // Issue and operand fetch
  ////////////////////////////////////////////////////////////////////////////

  operand_fetch #(
    .XLEN          (XLEN),
    .REG_BITS      (REG_BITS)
  ) u_operand_fetch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_i       (issue_i),
    .busy_o        (busy_o),
    .path_i        (path_i),
    .op_i          (op_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .rd_i          (rd_i),
    .imm_i         (imm_i),
    .use_imm_i     (use_imm_i),
    .branch_i      (branch_i),
    .cond_i        (cond_i),
    .pc_i          (pc_i),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o),
    .muldiv_busy_i (muldiv_busy),
    .flush_i       (branch_taken_o),
    .bundle        (bundle_if.producer),
    .fwd           (alu_res_if.forward)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute paths and retire
  ////////////////////////////////////////////////////////////////////////////

  alu_path #(
    .XLEN     (XLEN),
    .REG_BITS (REG_BITS)
  ) u_alu_path (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (branch_taken_o),
    .bundle   (bundle_if.consumer),
    .result   (alu_res_if.producer)
  );

  muldiv_path #(
    .XLEN     (XLEN),
    .REG_BITS (REG_BITS)
  ) u_muldiv_path (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .flush_i  (branch_taken_o),
    .bundle   (bundle_if.consumer),
    .busy_o   (muldiv_busy),
    .done_o   (muldiv_done),
    .rd_o     (muldiv_rd),
    .result_o (muldiv_result)
  );

  retire_unit #(
    .XLEN            (XLEN),
    .REG_BITS        (REG_BITS)
  ) u_retire_unit (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .alu             (alu_res_if.consumer),
    .muldiv_done_i   (muldiv_done),
    .muldiv_rd_i     (muldiv_rd),
    .muldiv_result_i (muldiv_result),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

endmodule

/* testbench/exec_checker.sv */
module exec_checker import exec_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         issue_i,
  input  exec_path_e   path_i,
  input  op_code_t     op_i,
  input  reg_addr_t    rs1_i,
  input  reg_addr_t    rs2_i,
  input  reg_addr_t    rd_i,
  input  word_t        imm_i,
  input  logic         use_imm_i,
  input  logic         branch_i,
  input  branch_cond_t cond_i,
  input  word_t        pc_i,
  input  logic         busy_i,
  input  logic         wb_valid_i,
  input  reg_addr_t    wb_rd_i,
  input  word_t        wb_data_i,
  input  logic         branch_taken_i,
  input  word_t        branch_target_i,
  output int           error_count_o,
  output int           check_count_o,
  output int           discard_count_o,
  output int           pending_o
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
  } wb_event_t;

  // Architectural register state in program order
  word_t     mirror [32];
  wb_event_t wb_queue [$];
  word_t     target_queue [$];
  int        discard_left;
  logic      check_reset_state;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t alu_model(op_code_t op, word_t a, word_t b);
    word_t      result;
    logic [4:0] shamt;
    shamt = b[4:0];
    case (alu_op_e'(op))
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_SLT:  result = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      ALU_SLTU: result = (a < b) ? word_t'(1) : word_t'(0);
      default:  result = '0;
    endcase
    return result;
  endfunction

  function automatic word_t muldiv_model(op_code_t op, word_t a, word_t b);
    logic [2*XLEN-1:0] product;
    word_t             result;
    product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op[1:0])
      2'd0:    result = product[XLEN-1:0];
      2'd1:    result = product[2*XLEN-1:XLEN];
      // Divide by zero per RV32 gives an all ones quotient and the dividend as remainder
      2'd2:    result = (b == '0) ? '1 : a / b;
      default: result = (b == '0) ? a : a % b;
    endcase
    return result;
  endfunction

  function automatic logic branch_model(branch_cond_t cond, word_t a, word_t b);
    logic taken;
    case (cond)
      3'b000:  taken = a == b;
      3'b001:  taken = a != b;
      3'b100:  taken = $signed(a) < $signed(b);
      3'b101:  taken = $signed(a) >= $signed(b);
      3'b110:  taken = a < b;
      3'b111:  taken = a >= b;
      default: taken = 1'b0;
    endcase
    return taken;
  endfunction

  task automatic model_issue();
    word_t     a;
    word_t     b;
    wb_event_t event_q;
    a = mirror[rs1_i];
    // Branches compare against rs2 even with an immediate present
    b = (use_imm_i && !branch_i) ? imm_i : mirror[rs2_i];
    if (branch_i) begin
      if (branch_model(cond_i, a, b)) begin
        target_queue.push_back(pc_i + imm_i);
        discard_left = 2;
      end
    end else begin
      event_q.rd   = rd_i;
      event_q.data = (path_i == PATH_MULDIV) ? muldiv_model(op_i, a, b) : alu_model(op_i, a, b);
      if (rd_i != '0) begin
        mirror[rd_i] = event_q.data;
        wb_queue.push_back(event_q);
      end
    end
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    check_count_o++;
    if (expected !== actual) begin
      error_count_o++;
      $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output comparison and issue tracking
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic      in_window;
    wb_event_t expected;
    if (reset_i) begin
      foreach (mirror[i]) begin
        mirror[i] = '0;
      end
      wb_queue.delete();
      target_queue.delete();
      discard_left      = 0;
      check_reset_state = 1'b1;
    end else begin
      if (check_reset_state) begin
        check_value("busy_o", '0, word_t'(busy_i));
        check_value("wb_valid_o", '0, word_t'(wb_valid_i));
        check_value("branch_taken_o", '0, word_t'(branch_taken_i));
        check_reset_state = 1'b0;
      end
      if (wb_valid_i) begin
        if (wb_queue.size() == 0) begin
          error_count_o++;
          $display("t=%0t writeback to x%0d arrived with no result outstanding", $time, wb_rd_i);
        end else begin
          expected = wb_queue.pop_front();
          check_value("wb_rd_o", word_t'(expected.rd), word_t'(wb_rd_i));
          check_value("wb_data_o", expected.data, wb_data_i);
        end
      end
      if (branch_taken_i) begin
        if (target_queue.size() == 0) begin
          error_count_o++;
          $display("t=%0t branch_taken_o pulsed but no taken branch was outstanding", $time);
        end else begin
          check_value("branch_target_o", target_queue.pop_front(), branch_target_i);
        end
      end
      // Two edges after a taken branch are flushed
      in_window = discard_left != 0;
      if (in_window) begin
        discard_left--;
      end
      if (issue_i && !busy_i) begin
        if (in_window) begin
          discard_count_o++;
        end else begin
          model_issue();
        end
      end
    end
    pending_o = wb_queue.size() + target_queue.size();
  end

endmodule

/* testbench/tb_exec_core.sv */
module tb_exec_core import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int QUIET_CYCLES   = 4;

  logic         clk_i;
  logic         reset_i;
  logic         issue_i;
  logic         busy_o;
  exec_path_e   path_i;
  op_code_t     op_i;
  reg_addr_t    rs1_i;
  reg_addr_t    rs2_i;
  reg_addr_t    rd_i;
  word_t        imm_i;
  logic         use_imm_i;
  logic         branch_i;
  branch_cond_t cond_i;
  word_t        pc_i;
  logic         wb_valid_o;
  reg_addr_t    wb_rd_o;
  word_t        wb_data_o;
  logic         branch_taken_o;
  word_t        branch_target_o;

  int        error_count;
  int        check_count;
  int        discard_count;
  int        pending;
  int        test_num;
  int        errors_at_start;
  logic      timed_out;
  reg_addr_t recent_rd [2];

  always #50 clk_i = ~clk_i;

  exec_core #(
    .XLEN     (XLEN),
    .REG_BITS (REG_BITS)
  ) dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .issue_i         (issue_i),
    .busy_o          (busy_o),
    .path_i          (path_i),
    .op_i            (op_i),
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .rd_i            (rd_i),
    .imm_i           (imm_i),
    .use_imm_i       (use_imm_i),
    .branch_i        (branch_i),
    .cond_i          (cond_i),
    .pc_i            (pc_i),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

  exec_checker u_exec_checker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .issue_i         (issue_i),
    .path_i          (path_i),
    .op_i            (op_i),
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .rd_i            (rd_i),
    .imm_i           (imm_i),
    .use_imm_i       (use_imm_i),
    .branch_i        (branch_i),
    .cond_i          (cond_i),
    .pc_i            (pc_i),
    .busy_i          (busy_o),
    .wb_valid_i      (wb_valid_o),
    .wb_rd_i         (wb_rd_o),
    .wb_data_i       (wb_data_o),
    .branch_taken_i  (branch_taken_o),
    .branch_target_i (branch_target_o),
    .error_count_o   (error_count),
    .check_count_o   (check_count),
    .discard_count_o (discard_count),
    .pending_o       (pending)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Mostly random, with values near zero and all ones for shifts and divides
  function automatic word_t random_word();
    word_t value;
    case ($urandom_range(3))
      0:       value = word_t'($urandom_range(15));
      1:       value = ~word_t'($urandom_range(15));
      default: value = word_t'($urandom);
    endcase
    return value;
  endfunction

  // Recent destinations exercise both forwarding sources
  function automatic reg_addr_t pick_source();
    reg_addr_t idx;
    case ($urandom_range(3))
      0:       idx = recent_rd[0];
      1:       idx = recent_rd[1];
      default: idx = reg_addr_t'($urandom_range(31));
    endcase
    return idx;
  endfunction

  function automatic reg_addr_t pick_dest();
    return ($urandom_range(7) == 0) ? reg_addr_t'(0) : reg_addr_t'($urandom_range(31, 1));
  endfunction

  task automatic drive_op(input exec_path_e path, input op_code_t op, input reg_addr_t rs1,
                          input reg_addr_t rs2, input reg_addr_t rd, input word_t imm,
                          input logic use_imm, input logic branch, input branch_cond_t cond,
                          input word_t pc);
    int waited;
    if (timed_out) begin
      return;
    end
    @(negedge clk_i);
    path_i    = path;
    op_i      = op;
    rs1_i     = rs1;
    rs2_i     = rs2;
    rd_i      = rd;
    imm_i     = imm;
    use_imm_i = use_imm;
    branch_i  = branch;
    cond_i    = cond;
    pc_i      = pc;
    issue_i   = 1'b1;
    waited    = 0;
    // Fields stay held until busy_o drops
    while (busy_o && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (busy_o) begin
      $display("t=%0t timeout: busy_o stayed high for %0d cycles", $time, waited);
      timed_out = 1'b1;
    end
  endtask

  task automatic issue_alu(input op_code_t op, input reg_addr_t rs1, input reg_addr_t rs2,
                           input reg_addr_t rd, input word_t imm, input logic use_imm);
    drive_op(PATH_ALU, op, rs1, rs2, rd, imm, use_imm, 1'b0, BR_EQ, '0);
    recent_rd[1] = recent_rd[0];
    recent_rd[0] = rd;
  endtask

  task automatic random_alu();
    issue_alu(op_code_t'($urandom_range(9)), pick_source(), pick_source(), pick_dest(),
              random_word(), $urandom_range(1) != 0);
  endtask

  task automatic random_muldiv();
    reg_addr_t rs2;
    reg_addr_t rd;
    rs2 = ($urandom_range(3) == 0) ? reg_addr_t'(0) : pick_source();
    rd  = pick_dest();
    drive_op(PATH_MULDIV, op_code_t'($urandom_range(3)), pick_source(), rs2, rd,
             random_word(), 1'b0, 1'b0, BR_EQ, '0);
    recent_rd[1] = recent_rd[0];
    recent_rd[0] = rd;
  endtask

  task automatic random_branch();
    reg_addr_t rs1;
    reg_addr_t rs2;
    rs1 = pick_source();
    rs2 = ($urandom_range(3) == 0) ? rs1 : pick_source();
    drive_op(PATH_ALU, ALU_SUB, rs1, rs2, pick_dest(), random_word(), $urandom_range(1) != 0,
             1'b1, branch_cond_t'($urandom_range(7)), word_t'($urandom) & ~word_t'(3));
  endtask

  // Idle until every expected result has arrived
  task automatic drain();
    int waited;
    int quiet;
    @(negedge clk_i);
    issue_i = 1'b0;
    waited  = 0;
    quiet   = 0;
    while (quiet < QUIET_CYCLES && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
      quiet = (pending == 0 && !busy_o) ? quiet + 1 : 0;
    end
    if (quiet < QUIET_CYCLES) begin
      $display("t=%0t timeout: %0d expected results never arrived", $time, pending);
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    int errors;
    drain();
    errors = error_count - errors_at_start;
    $display("test %0d %s: %s, %0d errors", test_num, name,
             (errors == 0 && !timed_out) ? "passed" : "failed", errors);
    test_num++;
    errors_at_start = error_count;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int kind;
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    issue_i   = 1'b0;
    path_i    = PATH_ALU;
    op_i      = '0;
    rs1_i     = '0;
    rs2_i     = '0;
    rd_i      = '0;
    imm_i     = '0;
    use_imm_i = 1'b0;
    branch_i  = 1'b0;
    cond_i    = '0;
    pc_i      = '0;
    timed_out = 1'b0;
    test_num  = 1;
    recent_rd[0] = '0;
    recent_rd[1] = '0;
    void'($urandom(32'hb8e4));
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    errors_at_start = error_count;

    issue_alu(ALU_ADD, 5'd1, 5'd2, 5'd3, '0, 1'b0);
    finish_test("reset state and ADD of x1 and x2");

    for (int r = 1; r < 32; r++) begin
      issue_alu(ALU_ADD, '0, '0, reg_addr_t'(r), random_word(), 1'b1);
    end
    for (int i = 0; i < 200; i++) begin
      random_alu();
    end
    finish_test("back-to-back ALU with forwarding");

    // The ALU op right behind each muldiv is held by busy_o
    for (int i = 0; i < 40; i++) begin
      random_muldiv();
      random_alu();
    end
    finish_test("MUL MULHU DIVU REMU with held issue");

    for (int i = 0; i < 60; i++) begin
      random_branch();
      random_alu();
      random_alu();
    end
    finish_test("branches and flush of younger operations");

    for (int i = 0; i < 300; i++) begin
      kind = $urandom_range(19);
      if (kind < 12) begin
        random_alu();
      end else if (kind < 15) begin
        random_muldiv();
      end else begin
        random_branch();
      end
    end
    drain();
    for (int r = 1; r < 32; r++) begin
      issue_alu(ALU_ADD, reg_addr_t'(r), '0, reg_addr_t'(r), '0, 1'b0);
    end
    finish_test("mixed stream and register readback");

    $display("tests %0d, checks %0d, errors %0d, discarded operations %0d",
             test_num - 1, check_count, error_count, discard_count);
    if (timed_out || error_count != 0) begin
      $display("** FAIL **");
    end else begin
      $display("** PASS **");
    end
    $finish;
  end

endmodule

/* exec_core.f */
src/exec_pkg.sv
src/exec_ifs.sv
src/operand_fetch.sv
src/alu_path.sv
src/muldiv_path.sv
src/retire_unit.sv
src/exec_core.sv
testbench/exec_checker.sv
testbench/tb_exec_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_exec_core -f exec_core.f \
  -Mdir obj_dir -o sim_exec_core > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_exec_core > sim.log 2>&1
cat sim.log
grep -qF -- '** FAIL **' sim.log && { echo "Simulation failed"; exit 1; }
grep -qF -- '** PASS **' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
